// File: tests/wbuf_stim.txt
# W gap addr data be = core write after gap idle cycles, C gap sent full = credit pulse
# C checks writes sent before it and core_full_o during it, E addr data be = expected memory write
# Two credits after reset, the third write waits for a returned credit
W 0 0010 a1a2a3a4 f
W 0 0020 b1b2b3b4 f
W 0 0030 c1c2c3c4 f
C 3 2 0
E 0010 a1a2a3a4 f
E 0020 b1b2b3b4 f
E 0030 c1c2c3c4 f
# No credits held, writes to 0040 merge around a write to 0050
W 3 0040 00003344 3
W 0 0040 ffbbffff 4
W 0 0050 cafef00d f
W 0 0040 77ee7788 5
W 0 0040 5a000000 8
C 2 3 0
# Write in the cycle 0040 is sent takes a new entry, the next one merges into it
W 0 0040 0000beef 3
W 0 0040 12340000 c
C 2 4 0
C 2 5 0
E 0040 5aee3388 f
E 0050 cafef00d f
E 0040 1234beef f
# Four distinct lines fill the buffer, one credit frees a slot
W 3 0100 00000001 f
W 0 0200 00000002 f
W 0 0300 00000003 f
W 0 0400 00000004 f
C 1 6 1
W 1 0500 00000005 f
C 1 7 1
C 1 8 0
C 1 9 0
C 1 10 0
E 0100 00000001 f
E 0200 00000002 f
E 0300 00000003 f
E 0400 00000004 f
E 0500 00000005 f

// File: vlog.f
+incdir+include
logic/wbuf_core_pkg.sv
logic/wbuf_mem_pkg.sv
logic/wbuf_cbuf.sv
logic/wbuf_addr_dir.sv
logic/wbuf_fifo.sv
logic/wbuf_credit_cnt.sv
logic/wbuf_ctrl.sv
logic/wbuf_top.sv
tests/tb_wbuf.sv

// File: Bender.yml
package:
  name: wbuf

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/wbuf_core_pkg.sv
      - logic/wbuf_mem_pkg.sv
      - logic/wbuf_cbuf.sv
      - logic/wbuf_addr_dir.sv
      - logic/wbuf_fifo.sv
      - logic/wbuf_credit_cnt.sv
      - logic/wbuf_ctrl.sv
      - logic/wbuf_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_wbuf.sv

// File: tests/tb_wbuf.sv
/*
 * Testbench for the write-coalescing store buffer
 * Replays core writes and credit pulses, checks each memory write in send order
 */
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_defs.svh"

module tb_wbuf;

    import wbuf_core_pkg::*;

    localparam int ClkPeriod       = 10;
    localparam int ResetCycles     = 8;
    localparam int CyclesPerRecord = 50;
    localparam int DrainCycles     = 20;
    localparam     StimFile        = "tests/wbuf_stim.txt";

    logic  clk;
    logic  rst_n;
    logic  core_wr;
    addr_t core_addr;
    data_t core_data;
    be_t   core_be;
    logic  core_full;
    logic  mem_wr;
    addr_t mem_addr;
    data_t mem_data;
    be_t   mem_be;
    logic  mem_credit;

    // Write and credit records replayed in file order
    logic [7:0] rec_kind [$];
    int         rec_gap  [$];
    addr_t      rec_addr [$];
    data_t      rec_data [$];
    be_t        rec_be   [$];
    int         rec_sent [$];
    logic       rec_full [$];

    // Memory writes still to come
    addr_t exp_addr [$];
    data_t exp_data [$];
    be_t   exp_be   [$];

    int   exp_total;
    int   sent_cnt;
    int   returned_cnt;
    logic stim_loaded;

    wbuf_top u_dut (
        .clk_i (clk), .rst_ni (rst_n), .core_wr_i (core_wr), .core_addr_i (core_addr),
        .core_data_i (core_data), .core_be_i (core_be), .core_full_o (core_full),
        .mem_wr_o (mem_wr), .mem_addr_o (mem_addr), .mem_data_o (mem_data),
        .mem_be_o (mem_be), .mem_credit_i (mem_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_be(input string name, input be_t got, input be_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic store_record(input logic [7:0] kind, input int gap, input addr_t addr,
                                input data_t data, input be_t be, input int sent,
                                input logic full);
        rec_kind.push_back(kind);
        rec_gap.push_back(gap);
        rec_addr.push_back(addr);
        rec_data.push_back(data);
        rec_be.push_back(be);
        rec_sent.push_back(sent);
        rec_full.push_back(full);
    endtask

    // W and C lines drive the DUT, E lines fill the expected send order
    task automatic load_stimulus();
        int               fd;
        int               code;
        int               gap;
        int               sent;
        int               full;
        logic [7:0]       kind;
        logic [8*128-1:0] rest;
        addr_t            addr;
        data_t            data;
        be_t              be;
        fd = $fopen(StimFile, "r");
        if (fd == 0) abort_run("Could not open the stimulus file");
        code = $fscanf(fd, " %c", kind);
        while (code == 1) begin
            case (kind)
                "W": begin
                    code = $fscanf(fd, "%d %h %h %h", gap, addr, data, be);
                    if (code != 4) abort_run("Malformed write record in the stimulus file");
                    store_record(kind, gap, addr, data, be, 0, 1'b0);
                end
                "C": begin
                    code = $fscanf(fd, "%d %d %d", gap, sent, full);
                    if (code != 3) abort_run("Malformed credit record in the stimulus file");
                    store_record(kind, gap, '0, '0, '0, sent, full[0]);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %h", addr, data, be);
                    if (code != 3) abort_run("Malformed expected record in the stimulus file");
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                    exp_be.push_back(be);
                end
                "#": code = $fgets(rest, fd);
                default: abort_run("Unknown record kind in the stimulus file");
            endcase
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            core_wr    <= 1'b0;
            mem_credit <= 1'b0;
        end
    endtask

    // Full must stay low in the cycle the write is taken
    task automatic apply_write(input addr_t addr, input data_t data, input be_t be);
        @(posedge clk);
        core_wr    <= 1'b1;
        core_addr  <= addr;
        core_data  <= data;
        core_be    <= be;
        mem_credit <= 1'b0;
        @(negedge clk);
        check_flag("core_full_o", core_full, 1'b0);
    endtask

    // Pulse one credit back, after checking how many writes left so far
    task automatic return_credit(input int sent_before, input logic full);
        @(posedge clk);
        core_wr    <= 1'b0;
        mem_credit <= 1'b1;
        check_count("mem_wr_o pulses", sent_cnt, sent_before);
        @(negedge clk);
        check_flag("core_full_o", core_full, full);
    endtask

    // Memory model matches every pulse against the oldest expected write
    always @(negedge clk) begin : mem_model
        if (rst_n) begin
            if (mem_wr) begin
                sent_cnt = sent_cnt + 1;
                if (sent_cnt > `WBUF_MEM_CREDITS + returned_cnt) begin
                    abort_run("Memory write issued without a credit held");
                end
                if (exp_addr.size() == 0) begin
                    abort_run("Memory write seen with no expected record left");
                end
                check_addr("mem_addr_o", mem_addr, exp_addr.pop_front());
                check_data("mem_data_o", mem_data, exp_data.pop_front());
                check_be("mem_be_o", mem_be, exp_be.pop_front());
            end
            // A credit returned now is usable from the next cycle
            if (mem_credit) returned_cnt = returned_cnt + 1;
        end
    end

    initial begin : main_seq
        rst_n        = 1'b0;
        core_wr      = 1'b0;
        core_addr    = '0;
        core_data    = '0;
        core_be      = '0;
        mem_credit   = 1'b0;
        sent_cnt     = 0;
        returned_cnt = 0;
        stim_loaded  = 1'b0;
        load_stimulus();
        exp_total   = exp_addr.size();
        stim_loaded = 1'b1;

        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("core_full_o", core_full, 1'b0);
        check_flag("mem_wr_o", mem_wr, 1'b0);

        for (int i = 0; i < rec_kind.size(); i++) begin
            idle_cycles(rec_gap[i]);
            if (rec_kind[i] == "W") begin
                apply_write(rec_addr[i], rec_data[i], rec_be[i]);
            end else begin
                return_credit(rec_sent[i], rec_full[i]);
            end
        end
        idle_cycles(1);

        // Wait for the last entries, then watch for stray writes
        while (exp_addr.size() != 0) @(posedge clk);
        repeat (DrainCycles) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

    initial begin : watchdog
        wait (stim_loaded);
        repeat (ResetCycles + CyclesPerRecord * (rec_kind.size() + exp_total)) @(posedge clk);
        abort_run("Timeout: the run did not finish within its cycle budget");
    end

endmodule

`default_nettype wire

// File: logic/wbuf_top.sv
/*
 * Write-coalescing store buffer
 * Merges core writes per line and sends them to memory in allocation order
 */
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_top (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 core_wr_i,
    input  wire wbuf_core_pkg::addr_t core_addr_i,
    input  wire wbuf_core_pkg::data_t core_data_i,
    input  wire wbuf_core_pkg::be_t   core_be_i,
    output logic                      core_full_o,
    output logic                      mem_wr_o,
    output wbuf_core_pkg::addr_t      mem_addr_o,
    output wbuf_core_pkg::data_t      mem_data_o,
    output wbuf_core_pkg::be_t        mem_be_o,
    input  wire logic                 mem_credit_i
);

    import wbuf_core_pkg::*;
    import wbuf_mem_pkg::*;

    logic                     alloc, merge, push, send, consume;
    logic                     dir_hit, fifo_empty;
    cbuf_id_t                 alloc_id, merge_id, push_id, send_id, dir_hit_id, fifo_head;
    logic [`WBUF_ENTRIES-1:0] valid;
    cbuf_entry_t              send_payload;
    credit_t                  credits;

    assign mem_wr_o   = send;
    assign mem_data_o = send_payload.data;
    assign mem_be_o   = send_payload.be;

    wbuf_ctrl u_ctrl (
        .core_wr_i (core_wr_i), .dir_hit_i (dir_hit), .dir_hit_id_i (dir_hit_id),
        .alloc_id_i (alloc_id), .fifo_empty_i (fifo_empty), .fifo_head_i (fifo_head),
        .credit_avail_i (credits), .alloc_o (alloc), .merge_o (merge),
        .merge_id_o (merge_id), .push_o (push), .push_id_o (push_id),
        .send_o (send), .send_id_o (send_id), .consume_o (consume)
    );

    wbuf_cbuf #(
        .NumEntries (`WBUF_ENTRIES), .payload_t (cbuf_entry_t), .id_t (cbuf_id_t),
        .data_t (data_t), .be_t (be_t)
    ) u_cbuf (
        .clk_i (clk_i), .rst_ni (rst_ni), .alloc_i (alloc),
        .alloc_data_i ('{data: core_data_i, be: core_be_i}), .alloc_id_o (alloc_id),
        .full_o (core_full_o), .merge_i (merge), .merge_id_i (merge_id),
        .merge_data_i (core_data_i), .merge_be_i (core_be_i), .release_i (send),
        .release_id_i (send_id), .release_payload_o (send_payload), .valid_o (valid)
    );

    // Sending entry is excluded and its address feeds the memory request
    wbuf_addr_dir u_dir (
        .clk_i (clk_i), .rst_ni (rst_ni), .wr_i (alloc), .wr_id_i (push_id),
        .wr_addr_i (core_addr_i), .lookup_addr_i (core_addr_i), .valid_i (valid),
        .exclude_i (send), .exclude_id_i (send_id), .hit_o (dir_hit),
        .hit_id_o (dir_hit_id), .head_addr_o (mem_addr_o), .head_id_i (send_id)
    );

    wbuf_fifo #(.Depth (`WBUF_ENTRIES), .item_t (cbuf_id_t)) u_fifo (
        .clk_i (clk_i), .rst_ni (rst_ni), .push_i (push), .push_item_i (push_id),
        .pop_i (send), .head_item_o (fifo_head), .empty_o (fifo_empty)
    );

    wbuf_credit_cnt u_credit (
        .clk_i (clk_i), .rst_ni (rst_ni), .consume_i (consume),
        .return_i (mem_credit_i), .credit_avail_o (credits)
    );

endmodule

`default_nettype wire

// File: logic/wbuf_ctrl.sv
/*
 * Write buffer control
 * Chooses merge or allocate per core write and sends the oldest entry
 * whenever memory has granted a credit
 */
`timescale 1ns/1ps
`default_nettype none

module wbuf_ctrl (
    // Core write strobe
    input  wire logic                    core_wr_i,

    // Directory lookup result
    input  wire logic                    dir_hit_i,
    input  wire wbuf_core_pkg::cbuf_id_t dir_hit_id_i,

    // Free slot offered by the buffer
    input  wire wbuf_core_pkg::cbuf_id_t alloc_id_i,

    // Queue head
    input  wire logic                    fifo_empty_i,
    input  wire wbuf_core_pkg::cbuf_id_t fifo_head_i,

    // Credits currently held
    input  wire wbuf_mem_pkg::credit_t   credit_avail_i,

    // Buffer strobes
    output logic                         alloc_o,
    output logic                         merge_o,
    output wbuf_core_pkg::cbuf_id_t      merge_id_o,

    // Queue push of the new entry
    output logic                         push_o,
    output wbuf_core_pkg::cbuf_id_t      push_id_o,

    // Send of the head entry
    output logic                         send_o,
    output wbuf_core_pkg::cbuf_id_t      send_id_o,
    output logic                         consume_o
);

    logic have_credit;

    // Sending needs at least one credit
    assign have_credit = (credit_avail_i != '0);

    // Merge into a pending entry on a directory hit
    // The directory already hides the entry being sent
    assign merge_o    = core_wr_i && dir_hit_i;
    assign merge_id_o = dir_hit_id_i;

    // Otherwise take the lowest free slot
    assign alloc_o = core_wr_i && !dir_hit_i;

    // New entries join the send order
    assign push_o    = alloc_o;
    assign push_id_o = alloc_id_i;

    // Oldest entry leaves when a credit is held
    // Same signal pops the queue and frees the slot
    assign send_o    = !fifo_empty_i && have_credit;
    assign send_id_o = fifo_head_i;

    // One credit per memory write
    assign consume_o = send_o;

endmodule

`default_nettype wire

// File: logic/wbuf_credit_cnt.sv
/*
 * Memory credit counter
 * Tracks write credits held toward memory
 */
`timescale 1ns/1ps
`default_nettype none

module wbuf_credit_cnt (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        consume_i,
    input  wire logic        return_i,
    output wbuf_mem_pkg::credit_t credit_avail_o
);

    import wbuf_mem_pkg::*;

    credit_t count_q;

    assign credit_avail_o = count_q;

    // Spend on send, refill on each returned pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= CreditInit;
        end else begin
            unique case ({consume_i, return_i})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/wbuf_fifo.sv
/*
 * In-order queue
 * Circular buffer of a generic item type with read and write pointers
 */
`timescale 1ns/1ps
`default_nettype none

module wbuf_fifo #(
    parameter int unsigned Depth = 4,
    parameter type item_t = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  push_i,
    input  wire item_t push_item_i,
    input  wire logic  pop_i,
    output item_t      head_item_o,
    output logic       empty_o
);

    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW = $clog2(Depth + 1);

    item_t             mem_q [Depth];
    logic [PtrW-1:0]   wr_ptr_q;
    logic [PtrW-1:0]   rd_ptr_q;
    logic [CntW-1:0]   count_q;
    logic              do_pop;

    assign empty_o     = (count_q == '0);
    assign head_item_o = mem_q[rd_ptr_q];

    // Ignore a pop on an empty queue
    assign do_pop = pop_i && !empty_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Push and pop together keep the count
            if (push_i && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && do_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Item storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_item_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/wbuf_addr_dir.sv
/*
 * Line-address directory
 * Finds the pending entry that an incoming write can merge into
 */
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_addr_dir (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      wr_i,
    input  wire wbuf_core_pkg::cbuf_id_t   wr_id_i,
    input  wire wbuf_core_pkg::addr_t      wr_addr_i,
    input  wire wbuf_core_pkg::addr_t      lookup_addr_i,
    input  wire logic [`WBUF_ENTRIES-1:0]  valid_i,
    input  wire logic                      exclude_i,
    input  wire wbuf_core_pkg::cbuf_id_t   exclude_id_i,
    output logic                           hit_o,
    output wbuf_core_pkg::cbuf_id_t        hit_id_o,
    output wbuf_core_pkg::addr_t           head_addr_o,
    input  wire wbuf_core_pkg::cbuf_id_t   head_id_i
);

    import wbuf_core_pkg::*;

    localparam int unsigned NumEntries = `WBUF_ENTRIES;

    addr_t addr_q [NumEntries];

    // Address of the entry at the queue head
    assign head_addr_o = addr_q[head_id_i];

    // Match against pending entries only
    // The entry leaving this cycle can no longer take bytes
    always_comb begin
        hit_o    = 1'b0;
        hit_id_o = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (valid_i[i] && (addr_q[i] == lookup_addr_i) &&
                !(exclude_i && (exclude_id_i == cbuf_id_t'(i)))) begin
                hit_o    = 1'b1;
                hit_id_o = cbuf_id_t'(i);
            end
        end
    end

    // Record the line address on allocation
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NumEntries; i++) begin
                addr_q[i] <= '0;
            end
        end else if (wr_i) begin
            addr_q[wr_id_i] <= wr_addr_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/wbuf_cbuf.sv
/*
 * Coalesce buffer
 * Allocates payload entries, merges bytes into pending ones and releases them
 */
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_cbuf #(
    parameter int unsigned NumEntries = `WBUF_ENTRIES,
    parameter type payload_t = wbuf_core_pkg::cbuf_entry_t,
    parameter type id_t      = wbuf_core_pkg::cbuf_id_t,
    parameter type data_t    = wbuf_core_pkg::data_t,
    parameter type be_t      = wbuf_core_pkg::be_t
) (
    input  wire logic            clk_i,
    input  wire logic            rst_ni,
    input  wire logic            alloc_i,
    input  wire payload_t        alloc_data_i,
    output id_t                  alloc_id_o,
    output logic                 full_o,
    input  wire logic            merge_i,
    input  wire id_t             merge_id_i,
    input  wire data_t           merge_data_i,
    input  wire be_t             merge_be_i,
    input  wire logic            release_i,
    input  wire id_t             release_id_i,
    output payload_t             release_payload_o,
    output logic [NumEntries-1:0] valid_o
);

    localparam int unsigned BeW = $bits(be_t);

    payload_t              entries_q [NumEntries];
    payload_t              entries_d [NumEntries];
    logic [NumEntries-1:0] valid_q;
    logic [NumEntries-1:0] valid_d;

    // Full once every slot holds a pending write
    assign full_o  = &valid_q;
    assign valid_o = valid_q;

    // Read port for the entry leaving to memory
    assign release_payload_o = entries_q[release_id_i];

    // Priority encoder, lowest free slot wins
    // Slots released this cycle only count as free from the next one
    always_comb begin
        alloc_id_o = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_id_o = id_t'(i);
            end
        end
    end

    always_comb begin
        valid_d   = valid_q;
        entries_d = entries_q;

        if (release_i) begin
            valid_d[release_id_i] = 1'b0;
        end

        // Overwrite enabled bytes, later write wins
        if (merge_i) begin
            for (int b = 0; b < BeW; b++) begin
                if (merge_be_i[b]) begin
                    entries_d[merge_id_i].data[8*b +: 8] = merge_data_i[8*b +: 8];
                end
            end
            entries_d[merge_id_i].be = entries_q[merge_id_i].be | merge_be_i;
        end

        // Fresh entry takes the whole payload
        if (alloc_i) begin
            valid_d[alloc_id_o]   = 1'b1;
            entries_d[alloc_id_o] = alloc_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        entries_q <= entries_d;
    end

endmodule

`default_nettype wire

// File: logic/wbuf_mem_pkg.sv
/*
 * Memory-side types of the write buffer
 * Credit pool for the memory write channel
 */
`default_nettype none

`include "wbuf_defs.svh"

package wbuf_mem_pkg;

    // Credit count, holds zero up to the full grant
    typedef logic [$clog2(`WBUF_MEM_CREDITS+1)-1:0] credit_t;

    // Count loaded at reset
    localparam credit_t CreditInit = credit_t'(`WBUF_MEM_CREDITS);

endpackage

`default_nettype wire

// File: logic/wbuf_core_pkg.sv
/*
 * Core-side types of the write buffer
 * Write request fields and the payload kept per entry
 */
`default_nettype none

`include "wbuf_defs.svh"

package wbuf_core_pkg;

    // Line address of a core write
    typedef logic [`WBUF_ADDR_W-1:0] addr_t;

    // Line data, one word
    typedef logic [`WBUF_DATA_W-1:0] data_t;

    // Byte enables, one per data byte
    typedef logic [`WBUF_BE_W-1:0] be_t;

    // Index of a buffer entry
    typedef logic [$clog2(`WBUF_ENTRIES)-1:0] cbuf_id_t;

    // Payload held in the coalesce buffer
    // Enables accumulate as writes merge in
    typedef struct packed {
        data_t data;
        be_t   be;
    } cbuf_entry_t;

endpackage

`default_nettype wire

// File: include/wbuf_defs.svh
/*
 * Write buffer configuration
 * Sizes of the coalescing store buffer and the memory credit pool
 */
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// Number of coalescing entries
`define WBUF_ENTRIES 4

// Line address width in bits
`define WBUF_ADDR_W 16

// Line data width in bits
`define WBUF_DATA_W 32

// One enable bit per data byte
`define WBUF_BE_W (`WBUF_DATA_W / 8)

// Credits granted by memory after reset
`define WBUF_MEM_CREDITS 2

`endif
